/* hdl/tex_cache_macros.svh */
// texture cache sizes
`ifndef TEX_CACHE_MACROS_SVH
`define TEX_CACHE_MACROS_SVH

// pixel coordinate width, x and y alike
`define TEX_ADDR_W 8
// log2 of block side, 2x2 pixel blocks
`define TEX_BLK_LOG 1
// line index, two y bits then two x bits
`define TEX_LINE_IDX_W 4
`define TEX_PIX_W 16
`define TEX_USER_W 4

// --------------------
// queue depths as log2
`define TEX_ITEM_DEPTH_LOG 3
`define TEX_FETCH_DEPTH_LOG 2
`define TEX_BEAT_DEPTH_LOG 3
// blocks in flight that still fit the beat queue
`define TEX_LOOKAHEAD ((1 << `TEX_BEAT_DEPTH_LOG) >> (2 * `TEX_BLK_LOG))

`endif

/* hdl/tex_cache_pkg.sv */
// texture cache stream types
`include "tex_cache_macros.svh"

package tex_cache_pkg;

	// client read request
	typedef struct packed {
		logic [`TEX_ADDR_W-1:0] x;
		logic [`TEX_ADDR_W-1:0] y;
		logic [`TEX_USER_W-1:0] user;
	} tex_req_t;

	// client response, one pixel
	typedef struct packed {
		logic [`TEX_PIX_W-1:0]  data;
		logic [`TEX_USER_W-1:0] user;
	} tex_rsp_t;

	// tag stage result for the data stage
	typedef struct packed {
		logic                       hit;
		logic [`TEX_LINE_IDX_W-1:0] line;
		logic [`TEX_BLK_LOG-1:0]    off_x;
		logic [`TEX_BLK_LOG-1:0]    off_y;
		logic [`TEX_USER_W-1:0]     user;
	} tex_item_t;

	// block fetch, block aligned coordinates
	typedef struct packed {
		logic [`TEX_ADDR_W-1:0] x;
		logic [`TEX_ADDR_W-1:0] y;
	} mem_req_t;

	// one returned pixel of a block
	typedef struct packed {
		logic [`TEX_PIX_W-1:0] data;
		logic                  last;
	} mem_beat_t;

endpackage

/* hdl/tex_stream_fifo.sv */
// valid/ready stream FIFO
`timescale 1ns/1ns

module tex_stream_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH_LOG = 2
) (
	input  logic     clk,
	input  logic     reset,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	localparam int DEPTH = 1 << DEPTH_LOG;
	localparam logic [DEPTH_LOG:0] FULL = (DEPTH_LOG + 1)'(DEPTH);

	payload_t             mem [DEPTH];
	logic [DEPTH_LOG-1:0] wr_ptr;
	logic [DEPTH_LOG-1:0] rd_ptr;
	// one bit wider than the pointers
	logic [DEPTH_LOG:0]   count;
	logic                 push;
	logic                 pop;

	assign in_ready  = count != FULL;
	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// equal pointers mean empty on a write and full on a read,
	// otherwise a write lands on unread data or a read passes the writer
	assert property (@(posedge clk) disable iff (reset)
		((push && wr_ptr == rd_ptr) |-> count == '0) and
		((pop && wr_ptr == rd_ptr) |-> count == FULL));

endmodule

/* hdl/tex_tag_lookup.sv */
// tag lookup and miss fork
`timescale 1ns/1ns
`include "tex_cache_macros.svh"

module tex_tag_lookup import tex_cache_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  tex_req_t  req,
	input  logic      req_valid,
	output logic      req_ready,
	output tex_item_t item,
	output logic      item_valid,
	input  logic      item_ready,
	output mem_req_t  fetch,
	output logic      fetch_valid,
	input  logic      fetch_ready
);

	localparam int LINES    = 1 << `TEX_LINE_IDX_W;
	localparam int IDX_HALF = `TEX_LINE_IDX_W / 2;
	localparam int BLK_W    = `TEX_ADDR_W - `TEX_BLK_LOG;
	localparam int TAG_W    = 2 * (BLK_W - IDX_HALF);

	// tag entries, valid bits kept apart so only they see reset
	logic [LINES-1:0]           tag_valid;
	logic [TAG_W-1:0]           tag_addr [LINES];

	logic [BLK_W-1:0]           blk_x;
	logic [BLK_W-1:0]           blk_y;
	logic [`TEX_LINE_IDX_W-1:0] idx;
	logic [TAG_W-1:0]           req_tag;
	logic                       hit;
	logic                       item_free;
	logic                       take;

	// --------------------
	// address split
	assign blk_x   = req.x[`TEX_ADDR_W-1:`TEX_BLK_LOG];
	assign blk_y   = req.y[`TEX_ADDR_W-1:`TEX_BLK_LOG];
	assign idx     = {blk_y[IDX_HALF-1:0], blk_x[IDX_HALF-1:0]};
	assign req_tag = {blk_y[BLK_W-1:IDX_HALF], blk_x[BLK_W-1:IDX_HALF]};
	assign hit     = tag_valid[idx] && (tag_addr[idx] == req_tag);

	// --------------------
	// accept
	assign item_free = !item_valid || item_ready;
	// a miss waits for an empty fetch register and room in the fetch queue,
	// so the fetch always leaves in its first cycle
	assign req_ready = item_free && (hit || (!fetch_valid && fetch_ready));
	assign take      = req_valid && req_ready;

	// allocate on miss, later requests to the block then hit
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_valid <= '0;
		end else if (take && !hit) begin
			tag_valid[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take && !hit) begin
			tag_addr[idx] <= req_tag;
		end
	end

	// --------------------
	// output registers
	always_ff @(posedge clk) begin
		if (take) begin
			item.hit   <= hit;
			item.line  <= idx;
			item.off_x <= req.x[`TEX_BLK_LOG-1:0];
			item.off_y <= req.y[`TEX_BLK_LOG-1:0];
			item.user  <= req.user;
		end
		if (take && !hit) begin
			fetch.x <= {blk_x, {`TEX_BLK_LOG{1'b0}}};
			fetch.y <= {blk_y, {`TEX_BLK_LOG{1'b0}}};
		end
	end

	// each output drains through its own handshake
	always_ff @(posedge clk) begin
		if (reset) begin
			item_valid  <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			if (item_valid && item_ready) begin
				item_valid <= 1'b0;
			end
			if (take) begin
				item_valid <= 1'b1;
			end
			if (fetch_valid && fetch_ready) begin
				fetch_valid <= 1'b0;
			end
			if (take && !hit) begin
				fetch_valid <= 1'b1;
			end
		end
	end

	// the fetch queue never stalls a fetch, so a fetch never outlives its item
	assert property (@(posedge clk) disable iff (reset)
		fetch_valid |-> (item_valid && fetch_ready));

endmodule

/* hdl/tex_fetch_limiter.sv */
// block fetch limiter
`timescale 1ns/1ns
`include "tex_cache_macros.svh"

module tex_fetch_limiter import tex_cache_pkg::*; #(
	parameter int LIMIT = `TEX_LOOKAHEAD
) (
	input  logic     clk,
	input  logic     reset,
	input  mem_req_t fetch,
	input  logic     fetch_valid,
	output logic     fetch_ready,
	output mem_req_t mem_req,
	output logic     mem_req_valid,
	input  logic     mem_req_ready,
	input  logic     fill_done
);

	localparam int CNT_W = $clog2(LIMIT + 1);
	localparam logic [CNT_W-1:0] MAX = CNT_W'(LIMIT);

	// blocks issued to memory but not yet written into a line
	logic [CNT_W-1:0] count;
	logic             at_limit;
	logic             issue;

	assign at_limit = count == MAX;

	// stream blocked in both directions at the limit
	assign mem_req       = fetch;
	assign mem_req_valid = fetch_valid && !at_limit;
	assign fetch_ready   = mem_req_ready && !at_limit;
	assign issue         = mem_req_valid && mem_req_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({issue, fill_done})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// fill_done from the data stage only ever retires an issued fetch
	assert property (@(posedge clk) disable iff (reset)
		(count <= MAX) && !(fill_done && count == '0));

endmodule

/* hdl/tex_block_store.sv */
// line memory, fill and readout
`timescale 1ns/1ns
`include "tex_cache_macros.svh"

module tex_block_store import tex_cache_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  tex_item_t item,
	input  logic      item_valid,
	output logic      item_ready,
	input  mem_beat_t beat,
	input  logic      beat_valid,
	output logic      beat_ready,
	output logic      fill_done,
	output tex_rsp_t  rsp,
	output logic      rsp_valid,
	input  logic      rsp_ready
);

	localparam int OFF_W  = 2 * `TEX_BLK_LOG;
	localparam int MEM_AW = `TEX_LINE_IDX_W + OFF_W;
	localparam logic [OFF_W-1:0] LAST_OFF = '1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FILL,
		ST_READ
	} state_t;

	state_t                state;
	// item being served, held across a fill
	tex_item_t             cur;
	tex_item_t             rd_item;
	logic [OFF_W-1:0]      fill_cnt;
	logic [`TEX_PIX_W-1:0] line_mem [1 << MEM_AW];
	logic [MEM_AW-1:0]     rd_addr;
	logic                  rsp_free;
	logic                  item_take;
	logic                  beat_take;
	logic                  rd_en;

	// --------------------
	// handshakes
	assign rsp_free   = !rsp_valid || rsp_ready;
	// no new item while the response is stuck
	assign item_ready = (state == ST_IDLE) && rsp_free;
	assign item_take  = item_valid && item_ready;
	assign beat_ready = state == ST_FILL;
	assign beat_take  = beat_valid && beat_ready;
	assign fill_done  = beat_take && beat.last;

	// hits read straight from the queue head
	assign rd_item = (state == ST_IDLE) ? item : cur;
	assign rd_addr = {rd_item.line, rd_item.off_y, rd_item.off_x};
	assign rd_en   = (item_take && item.hit) || ((state == ST_READ) && rsp_free);

	// --------------------
	// line memory
	// beats arrive x fastest, so beat n lands at offset n
	always_ff @(posedge clk) begin
		if (beat_take) begin
			line_mem[{cur.line, fill_cnt}] <= beat.data;
		end
	end

	// registered read into the response
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rsp.data <= line_mem[rd_addr];
			rsp.user <= rd_item.user;
		end
		if (item_take) begin
			cur <= item;
		end
	end

	// --------------------
	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			fill_cnt  <= '0;
			rsp_valid <= 1'b0;
		end else begin
			if (rd_en) begin
				rsp_valid <= 1'b1;
			end else if (rsp_ready) begin
				rsp_valid <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					// miss, wait for its block
					if (item_take && !item.hit) begin
						state    <= ST_FILL;
						fill_cnt <= '0;
					end
				end
				ST_FILL: begin
					if (beat_take) begin
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_cnt == LAST_OFF) begin
							state <= ST_READ;
						end
					end
				end
				ST_READ: begin
					if (rsp_free) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// memory framing must line up with the fill count
	assert property (@(posedge clk) disable iff (reset)
		beat_take |-> (beat.last == (fill_cnt == LAST_OFF)));

endmodule

/* hdl/tex_cache_top.sv */
// lookahead texture cache top
`timescale 1ns/1ns
`include "tex_cache_macros.svh"

module tex_cache_top import tex_cache_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  tex_req_t  req,
	input  logic      req_valid,
	output logic      req_ready,
	output tex_rsp_t  rsp,
	output logic      rsp_valid,
	input  logic      rsp_ready,
	output mem_req_t  mem_req,
	output logic      mem_req_valid,
	input  logic      mem_req_ready,
	input  mem_beat_t mem_beat,
	input  logic      mem_beat_valid,
	output logic      mem_beat_ready
);

	// tag stage outputs
	tex_item_t tag_item;
	logic      tag_item_valid;
	logic      tag_item_ready;
	mem_req_t  tag_fetch;
	logic      tag_fetch_valid;
	logic      tag_fetch_ready;

	// queue heads
	tex_item_t q_item;
	logic      q_item_valid;
	logic      q_item_ready;
	mem_req_t  q_fetch;
	logic      q_fetch_valid;
	logic      q_fetch_ready;
	mem_beat_t q_beat;
	logic      q_beat_valid;
	logic      q_beat_ready;

	logic      fill_done;

	// --------------------
	// lookup runs ahead of the data stage
	tex_tag_lookup tag_lookup_inst (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.item        (tag_item),
		.item_valid  (tag_item_valid),
		.item_ready  (tag_item_ready),
		.fetch       (tag_fetch),
		.fetch_valid (tag_fetch_valid),
		.fetch_ready (tag_fetch_ready)
	);

	tex_stream_fifo #(
		.payload_t (tex_item_t),
		.DEPTH_LOG (`TEX_ITEM_DEPTH_LOG)
	) item_queue_inst (
		.clk       (clk),
		.reset     (reset),
		.in_data   (tag_item),
		.in_valid  (tag_item_valid),
		.in_ready  (tag_item_ready),
		.out_data  (q_item),
		.out_valid (q_item_valid),
		.out_ready (q_item_ready)
	);

	tex_stream_fifo #(
		.payload_t (mem_req_t),
		.DEPTH_LOG (`TEX_FETCH_DEPTH_LOG)
	) fetch_queue_inst (
		.clk       (clk),
		.reset     (reset),
		.in_data   (tag_fetch),
		.in_valid  (tag_fetch_valid),
		.in_ready  (tag_fetch_ready),
		.out_data  (q_fetch),
		.out_valid (q_fetch_valid),
		.out_ready (q_fetch_ready)
	);

	// --------------------
	// memory side
	tex_fetch_limiter #(
		.LIMIT (`TEX_LOOKAHEAD)
	) fetch_limiter_inst (
		.clk           (clk),
		.reset         (reset),
		.fetch         (q_fetch),
		.fetch_valid   (q_fetch_valid),
		.fetch_ready   (q_fetch_ready),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.fill_done     (fill_done)
	);

	// sized so the limiter keeps it from filling up
	tex_stream_fifo #(
		.payload_t (mem_beat_t),
		.DEPTH_LOG (`TEX_BEAT_DEPTH_LOG)
	) beat_queue_inst (
		.clk       (clk),
		.reset     (reset),
		.in_data   (mem_beat),
		.in_valid  (mem_beat_valid),
		.in_ready  (mem_beat_ready),
		.out_data  (q_beat),
		.out_valid (q_beat_valid),
		.out_ready (q_beat_ready)
	);

	// --------------------
	// data stage
	tex_block_store block_store_inst (
		.clk        (clk),
		.reset      (reset),
		.item       (q_item),
		.item_valid (q_item_valid),
		.item_ready (q_item_ready),
		.beat       (q_beat),
		.beat_valid (q_beat_valid),
		.beat_ready (q_beat_ready),
		.fill_done  (fill_done),
		.rsp        (rsp),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready)
	);

endmodule

/* testbench/tb_tex_cache.sv */
// texture cache testbench
`timescale 1ns/1ns
`include "tex_cache_macros.svh"

module tb_tex_cache import tex_cache_pkg::*;;

	localparam int N_ROWS = 24;
	localparam int BLK_W  = `TEX_ADDR_W - `TEX_BLK_LOG;

	// one stimulus row, expected response follows from x, y and user
	typedef struct {
		string    name;
		tex_req_t req;
	} row_t;

	logic      clk;
	logic      reset;
	tex_req_t  req;
	logic      req_valid;
	logic      req_ready;
	tex_rsp_t  rsp;
	logic      rsp_valid;
	logic      rsp_ready;
	mem_req_t  mem_req;
	logic      mem_req_valid;
	logic      mem_req_ready;
	mem_beat_t mem_beat;
	logic      mem_beat_valid;
	logic      mem_beat_ready;

	row_t      rows [N_ROWS];
	// predicted fetches, in order, with the row that caused each
	mem_req_t  exp_fetch [$];
	string     fetch_names [$];
	// fetches seen at the memory port
	mem_req_t  fetch_log [$];
	int        rsp_cnt = 0;
	int        run_errors = 0;
	int        seq_errors = 0;
	tex_rsp_t  exp_rsp;

	tex_cache_top tex_cache_top_inst (
		.clk            (clk),
		.reset          (reset),
		.req            (req),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.rsp            (rsp),
		.rsp_valid      (rsp_valid),
		.rsp_ready      (rsp_ready),
		.mem_req        (mem_req),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_beat       (mem_beat),
		.mem_beat_valid (mem_beat_valid),
		.mem_beat_ready (mem_beat_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic set_row(input int i, input string name, input int x, input int y,
			input int user);
		rows[i].name     = name;
		rows[i].req.x    = 8'(x);
		rows[i].req.y    = 8'(y);
		rows[i].req.user = 4'(user);
	endtask

	// --------------------
	// stimulus table
	task automatic fill_table();
		// one block, first access misses
		set_row(0, "first_block", 0, 0, 1);
		set_row(1, "first_block", 1, 0, 2);
		set_row(2, "first_block", 0, 1, 3);
		set_row(3, "first_block", 1, 1, 4);
		// neighbours land in other lines
		set_row(4, "neighbor", 2, 0, 5);
		set_row(5, "neighbor", 3, 1, 6);
		set_row(6, "neighbor", 0, 2, 7);
		set_row(7, "neighbor", 2, 2, 8);
		// blocks (0,0) and (8,0) share line 0
		set_row(8, "conflict", 8, 0, 9);
		set_row(9, "conflict", 0, 0, 10);
		set_row(10, "conflict", 9, 1, 11);
		set_row(11, "conflict", 1, 1, 12);
		// line 0 holds (0,0) again
		set_row(12, "rehit", 0, 1, 13);
		set_row(13, "rehit", 1, 0, 14);
		set_row(14, "far", 100, 50, 15);
		set_row(15, "far", 101, 51, 0);
		set_row(16, "far", 200, 7, 1);
		set_row(17, "far", 6, 200, 2);
		set_row(18, "far", 255, 255, 3);
		set_row(19, "far", 254, 254, 4);
		set_row(20, "spread", 16, 16, 5);
		set_row(21, "spread", 17, 17, 6);
		set_row(22, "spread", 40, 8, 7);
		set_row(23, "spread", 41, 9, 8);
	endtask

	// --------------------
	// reference cache, direct mapped, 16 lines
	task automatic predict_fetches();
		logic [15:0]      ref_valid;
		logic [2*BLK_W-1:0] ref_blk [16];
		logic [BLK_W-1:0] bx;
		logic [BLK_W-1:0] by;
		logic [3:0]       idx;
		mem_req_t         blk;
		int               i;
		ref_valid = '0;
		for (i = 0; i < N_ROWS; i++) begin
			bx  = rows[i].req.x[`TEX_ADDR_W-1:`TEX_BLK_LOG];
			by  = rows[i].req.y[`TEX_ADDR_W-1:`TEX_BLK_LOG];
			// two low y bits, then two low x bits
			idx = {by[1:0], bx[1:0]};
			if (!ref_valid[idx] || ref_blk[idx] != {by, bx}) begin
				ref_valid[idx] = 1'b1;
				ref_blk[idx]   = {by, bx};
				blk.x          = {bx, 1'b0};
				blk.y          = {by, 1'b0};
				exp_fetch.push_back(blk);
				fetch_names.push_back(rows[i].name);
			end
		end
	endtask

	// --------------------
	// main sequence
	initial begin
		int i;
		void'($urandom(32'h1b20_ba39));
		reset     = 1'b1;
		req       = '0;
		req_valid = 1'b0;
		fill_table();
		predict_fetches();
		repeat (3) @(posedge clk);
		assert (!rsp_valid && !mem_req_valid) else begin
			$display("outputs still valid while reset was held");
			seq_errors++;
		end
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		// back to back requests, held until taken
		for (i = 0; i < N_ROWS; i++) begin
			req       = rows[i].req;
			req_valid = 1'b1;
			@(posedge clk);
			while (!req_ready) @(posedge clk);
			#1;
		end
		req_valid = 1'b0;
		while (rsp_cnt < N_ROWS) @(posedge clk);
		// give stray responses or fetches time to show up
		repeat (20) @(posedge clk);
		assert (fetch_log.size() == exp_fetch.size()) else begin
			$display("Fail fetch_count: expected %0d actual %0d",
				exp_fetch.size(), fetch_log.size());
			seq_errors++;
		end
		$display("errors: %0d in stream checks, %0d in sequence checks",
			run_errors, seq_errors);
		if (run_errors + seq_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// random back-pressure on both outputs
	initial begin
		rsp_ready     = 1'b0;
		mem_req_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			rsp_ready     = ($urandom % 2) != 0;
			mem_req_ready = ($urandom % 4) != 0;
		end
	end

	// --------------------
	// memory model, four beats per fetch, x fastest
	initial begin
		int       served;
		int       delay;
		int       k;
		mem_req_t blk;
		served         = 0;
		mem_beat       = '0;
		mem_beat_valid = 1'b0;
		forever begin
			@(negedge clk);
			if (served < fetch_log.size()) begin
				blk = fetch_log[served];
				served++;
				delay = $urandom % 6;
				repeat (delay) @(posedge clk);
				@(posedge clk);
				#1;
				for (k = 0; k < 4; k++) begin
					// pixel value is y then x
					mem_beat.data  = {blk.y + 8'(k >> 1), blk.x + 8'(k & 1)};
					mem_beat.last  = (k == 3);
					mem_beat_valid = 1'b1;
					@(posedge clk);
					while (!mem_beat_ready) @(posedge clk);
					#1;
				end
				mem_beat_valid = 1'b0;
			end
		end
	end

	// --------------------
	// stream checks, sampled at the rising edge
	always @(posedge clk) begin
		if (!reset) begin
			if (mem_req_valid && mem_req_ready) begin
				assert (fetch_log.size() < exp_fetch.size()) else begin
					$display("memory request %h beyond the predicted misses", mem_req);
					run_errors++;
				end
				if (fetch_log.size() < exp_fetch.size()) begin
					assert (mem_req == exp_fetch[fetch_log.size()]) else begin
						$display("Fail %s: expected %h actual %h",
							fetch_names[fetch_log.size()],
							exp_fetch[fetch_log.size()], mem_req);
						run_errors++;
					end
				end
				fetch_log.push_back(mem_req);
			end
			// limiter keeps room for every beat
			if (mem_beat_valid) begin
				assert (mem_beat_ready) else begin
					$display("beat offered while the beat FIFO was full");
					run_errors++;
				end
			end
			if (rsp_valid && rsp_ready) begin
				assert (rsp_cnt < N_ROWS) else begin
					$display("response %h arrived after the last request was answered", rsp);
					run_errors++;
				end
				if (rsp_cnt < N_ROWS) begin
					exp_rsp.data = {rows[rsp_cnt].req.y, rows[rsp_cnt].req.x};
					exp_rsp.user = rows[rsp_cnt].req.user;
					assert (rsp == exp_rsp) else begin
						$display("Fail %s: expected %h actual %h",
							rows[rsp_cnt].name, exp_rsp, rsp);
						run_errors++;
					end
				end
				rsp_cnt++;
			end
		end
	end

	// watchdog, 200 cycles per table row
	initial begin
		repeat (N_ROWS * 200) @(posedge clk);
		$display("timeout with %0d of %0d responses received", rsp_cnt, N_ROWS);
		$display("sim failed");
		$finish;
	end

endmodule

/* tex_cache.f */
+incdir+hdl
hdl/tex_cache_pkg.sv
hdl/tex_stream_fifo.sv
hdl/tex_tag_lookup.sv
hdl/tex_fetch_limiter.sv
hdl/tex_block_store.sv
hdl/tex_cache_top.sv
testbench/tb_tex_cache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the texture cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_tex_cache \
	-f tex_cache.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vtb_tex_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^sim passed$"; then
	exit 0
fi
exit 1
